/* dv/lsuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsuTb;

    localparam int MaxLines    = 64;
    localparam int Fields      = 7;  // Columns per stim line
    localparam int AckNegedges = 4;  // Capture edge plus 3 cycles

    logic              clk;
    logic              reset;
    logic              reqIn;
    lsuOpPkg::lsuReq_t reqData;
    logic              ackOut;
    memPkg::lsuRsp_t   rsp;

    logic [31:0] stimMem [MaxLines*Fields];
    int          numLines;
    int          cycleCount;
    int          cycleLimit;
    int          valueErrors;
    int          protoErrors;  // Handshake and latency problems

    lsuTop u_dut (
        .clk     (clk),
        .reset   (reset),
        .reqIn   (reqIn),
        .reqData (reqData),
        .ackOut  (ackOut),
        .rsp     (rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Run stopped after %0d cycles without finishing the accesses", cycleCount);
            finishRun(1'b1);
        end
    end

    task automatic finishRun(input logic timedOut);
        $display("Errors: value %0d, handshake %0d, timeout %0d",
                 valueErrors, protoErrors, timedOut);
        if (!timedOut && valueErrors == 0 && protoErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic compareField(input string name, input int idx,
                                input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("FAILED %s (access %0d): expected 0x%08h, got 0x%08h", name, idx, exp, got);
            valueErrors++;
        end
    endtask

    task automatic checkLoad(input int idx, input memPkg::lsuRsp_t exp,
                             input memPkg::lsuRsp_t got);
        compareField("rsp.tag", idx, exp.tag, got.tag);
        compareField("rsp.loadData", idx, exp.loadData, got.loadData);
        compareField("rsp.wasLoad", idx, 32'(1'b1), 32'(got.wasLoad));
        compareField("rsp.fault", idx, 32'(exp.fault), 32'(got.fault));
    endtask

    task automatic checkStore(input int idx, input memPkg::lsuRsp_t exp,
                              input memPkg::lsuRsp_t got);
        compareField("rsp.tag", idx, exp.tag, got.tag);
        compareField("rsp.loadData", idx, 32'd0, got.loadData);  // Stores return no data
        compareField("rsp.wasLoad", idx, 32'(1'b0), 32'(got.wasLoad));
        compareField("rsp.fault", idx, 32'(exp.fault), 32'(got.fault));
    endtask

    task automatic checkHeld(input int idx, input memPkg::lsuRsp_t exp,
                             input memPkg::lsuRsp_t got);
        if (got !== exp) begin
            $display("FAILED rsp held (access %0d): expected 0x%h, got 0x%h", idx, exp, got);
            valueErrors++;
        end
    endtask

    // Sampled on falling edges, away from the DUT's register updates
    task automatic waitAck(input logic level, input int limit, output int waited);
        waited = 0;
        while (ackOut !== level && waited < limit) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic runAccess(input int idx, input int expWait);
        int              base;
        int              waited;
        int              hold;
        memPkg::lsuRsp_t exp;
        memPkg::lsuRsp_t first;
        base              = idx * Fields;
        reqData.isLoad    = stimMem[base][0];
        reqData.isStore   = !stimMem[base][0];
        reqData.funct3    = lsuOpPkg::accessCode_e'(stimMem[base+1][2:0]);
        reqData.addr      = stimMem[base+2];
        reqData.storeData = stimMem[base+3];
        reqData.tag       = stimMem[base+4];
        exp.tag           = stimMem[base+4];
        exp.loadData      = stimMem[base+5];
        exp.wasLoad       = stimMem[base][0];
        exp.fault         = stimMem[base+6][0];
        reqIn = 1'b1;
        waitAck(1'b1, expWait + 10, waited);
        if (ackOut !== 1'b1) begin
            $display("Access %0d got no acknowledge within %0d cycles", idx, waited);
            protoErrors++;
        end else if (waited != expWait) begin
            $display("Access %0d was acknowledged after %0d cycles instead of %0d",
                     idx, waited, expWait);
            protoErrors++;
        end
        first = rsp;
        if (exp.wasLoad) begin
            checkLoad(idx, exp, first);
        end else begin
            checkStore(idx, exp, first);
        end
        for (hold = 0; hold < idx % 3; hold++) begin  // Back-pressure on some accesses
            @(negedge clk);
            if (ackOut !== 1'b1) begin
                $display("Access %0d lost its acknowledge while the request was held", idx);
                protoErrors++;
            end
            checkHeld(idx, exp, rsp);
        end
        reqIn   = 1'b0;
        reqData = '0;
        waitAck(1'b0, 10, waited);
        if (ackOut !== 1'b0) begin
            $display("Access %0d kept its acknowledge after the request dropped", idx);
            protoErrors++;
        end else if (waited != 1) begin
            $display("Access %0d dropped its acknowledge after %0d cycles", idx, waited);
            protoErrors++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        reqIn       = 1'b0;
        reqData     = '0;
        cycleCount  = 0;
        cycleLimit  = 0;
        valueErrors = 0;
        protoErrors = 0;
        for (int k = 0; k < MaxLines * Fields; k++) begin
            stimMem[k] = 32'hffff_ffff;  // End marker for unused lines
        end
        $readmemh("dv/lsu_stim.txt", stimMem);
        numLines = 0;
        while (numLines < MaxLines && stimMem[numLines*Fields] !== 32'hffff_ffff) begin
            numLines++;
        end
        cycleLimit = `LSU_MEM_WORDS + 10 * numLines + 100;
        if (numLines == 0) begin
            $display("The stim file holds no accesses");
            protoErrors++;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // First request is raised during the fill
        for (int i = 0; i < numLines; i++) begin
            runAccess(i, (i == 0) ? `LSU_MEM_WORDS + AckNegedges : AckNegedges);
        end
        finishRun(1'b0);
    end

endmodule

`default_nettype wire

/* dv/lsu_stim.txt */
// kind(1 load, 0 store) funct3 addr storeData tag expLoadData expFault
// all fields hex, one access per line
1 2 00000000 00000000 a5000001 00000003 0
1 2 00001ffc 00000000 a5000002 00000802 0
1 2 00000190 00000000 a5000003 00000067 0
0 0 00000010 deadbeaa a5000004 00000000 0
1 2 00000010 00000000 a5000005 000000aa 0
0 0 00000011 11223381 a5000006 00000000 0
1 2 00000010 00000000 a5000007 000081aa 0
0 0 00000012 000000f0 a5000008 00000000 0
1 2 00000010 00000000 a5000009 00f081aa 0
0 0 00000013 ffffff7e a500000a 00000000 0
1 2 00000010 00000000 a500000b 7ef081aa 0
0 1 00000018 cafe8001 a500000c 00000000 0
1 2 00000018 00000000 a500000d 00008001 0
0 1 0000001a 1234f00d a500000e 00000000 0
1 2 00000018 00000000 a500000f f00d8001 0
0 2 00000020 89abcdef a5000010 00000000 0
1 2 00000020 00000000 a5000011 89abcdef 0
1 0 00000010 00000000 a5000012 ffffffaa 0
1 4 00000010 00000000 a5000013 000000aa 0
1 0 00000011 00000000 a5000014 ffffff81 0
1 4 00000011 00000000 a5000015 00000081 0
1 1 0000001a 00000000 a5000016 fffff00d 0
1 5 0000001a 00000000 a5000017 0000f00d 0
1 1 00000012 00000000 a5000018 00007ef0 0
1 1 00000011 00000000 a5000019 00000000 1
0 1 00000019 ffffffff a500001a 00000000 1
1 2 00000012 00000000 a500001b 00000000 1
0 2 00000022 ffffffff a500001c 00000000 1
1 3 00000020 00000000 a500001d 00000000 1
0 6 00000020 ffffffff a500001e 00000000 1
1 7 00000010 00000000 a500001f 00000000 1
1 2 00000018 00000000 a5000020 f00d8001 0
1 2 00000020 00000000 a5000021 89abcdef 0

/* hw/accessDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module accessDecode (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        capture,
    input  wire lsuOpPkg::lsuReq_t     reqData,
    output memPkg::memWrite_t          memWr,
    output logic [`LSU_WORD_IDX_W-1:0] rdIdx,
    output memPkg::laneSel_t           lane,
    output logic [`LSU_TAG_W-1:0]      tag,
    output logic                       isLoad,
    output logic                       fault
);

    logic [1:0]                 offNext;
    logic [3:0]                 beNext;
    logic                       badCode;
    logic                       misaligned;
    logic                       faultNext;
    logic                       writeEnQ;
    logic [`LSU_WORD_IDX_W-1:0] wordIdxQ;
    logic [3:0]                 byteEnQ;
    memPkg::memWord_u           wrDataQ;

    always_comb begin
        offNext    = reqData.addr[1:0];
        beNext     = 4'b0000;
        badCode    = 1'b0;
        misaligned = 1'b0;
        case (reqData.funct3)
            lsuOpPkg::accByte, lsuOpPkg::accByteU: begin
                beNext = 4'b0001 << offNext;
            end
            lsuOpPkg::accHalf, lsuOpPkg::accHalfU: begin
                beNext     = 4'b0011 << offNext;
                misaligned = offNext[0];
            end
            lsuOpPkg::accWord: begin
                beNext     = 4'b1111;
                misaligned = |offNext;
            end
            default: badCode = 1'b1;   // 011, 110, 111
        endcase
        // Unsigned variants exist only for loads
        if (reqData.isStore && (reqData.funct3 == lsuOpPkg::accByteU ||
                                reqData.funct3 == lsuOpPkg::accHalfU)) begin
            badCode = 1'b1;
        end
        faultNext = badCode | misaligned;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writeEnQ <= 1'b0;
            fault    <= 1'b0;
        end else begin
            writeEnQ <= capture && reqData.isStore && !faultNext;  // One cycle only
            if (capture) begin
                fault <= faultNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wordIdxQ     <= reqData.addr[`LSU_WORD_IDX_W+1:2];
            byteEnQ      <= beNext;
            wrDataQ.word <= reqData.storeData << {offNext, 3'b000};  // Move into lane
            lane         <= '{offset: offNext, funct3: reqData.funct3};
            tag          <= reqData.tag;
            isLoad       <= reqData.isLoad;
        end
    end

    assign memWr = '{writeEn: writeEnQ, wordIdx: wordIdxQ, byteEn: byteEnQ, wrData: wrDataQ};
    assign rdIdx = wordIdxQ;

    noWriteOnFault: assert property (@(posedge clk) disable iff (reset)
        !(memWr.writeEn && fault));

endmodule

`default_nettype wire

/* hw/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module dataMemory (
    input  wire                        clk,
    input  wire                        reset,
    input  wire memPkg::memWrite_t     memWr,
    input  wire [`LSU_WORD_IDX_W-1:0]  rdIdx,
    output memPkg::memWord_u           rdWord,
    output logic                       ready
);

    memPkg::memWord_u           mem [`LSU_MEM_WORDS];
    logic [`LSU_WORD_IDX_W-1:0] fillIdx;
    logic                       wrEn;
    logic [`LSU_WORD_IDX_W-1:0] wrIdx;
    logic [3:0]                 wrBe;
    memPkg::memWord_u           wrWord;

    // Fill sequencer, one word per cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fillIdx <= '0;
            ready   <= 1'b0;
        end else if (!ready) begin
            fillIdx <= fillIdx + 1'b1;  // Wraps to zero after the last word
            if (fillIdx == `LSU_WORD_IDX_W'(`LSU_MEM_WORDS - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    // Single write port shared by the fill and the store path
    always_comb begin
        if (!ready) begin
            wrEn        = 1'b1;
            wrIdx       = fillIdx;
            wrBe        = 4'b1111;
            wrWord.word = 32'(fillIdx) + 32'd3;  // Initial image is index + 3
        end else begin
            wrEn   = memWr.writeEn;
            wrIdx  = memWr.wordIdx;
            wrBe   = memWr.byteEn;
            wrWord = memWr.wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (wrBe[b]) begin
                    mem[wrIdx].bytes[b] <= wrWord.bytes[b];
                end
            end
        end
    end

    // Registered read, old data on a same-index write
    always_ff @(posedge clk) begin
        rdWord <= mem[rdIdx];
    end

    noWriteDuringFill: assert property (@(posedge clk) disable iff (reset)
        memWr.writeEn |-> ready);

endmodule

`default_nettype wire

/* hw/loadExtract.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module loadExtract (
    input  wire memPkg::memWord_u     rdWord,
    input  wire memPkg::laneSel_t     lane,
    input  wire [`LSU_TAG_W-1:0]      tag,
    input  wire                       isLoad,
    input  wire                       fault,
    output memPkg::lsuRsp_t           rspNext
);

    logic [7:0]  selByte;
    logic [15:0] selHalf;
    logic [31:0] loadData;

    assign selByte = rdWord.bytes[lane.offset];
    assign selHalf = rdWord.halves[lane.offset[1]];  // Offset is aligned here

    always_comb begin
        loadData = 32'd0;
        if (isLoad && !fault) begin
            case (lane.funct3)
                lsuOpPkg::accByte:  loadData = {{24{selByte[7]}}, selByte};
                lsuOpPkg::accHalf:  loadData = {{16{selHalf[15]}}, selHalf};
                lsuOpPkg::accWord:  loadData = rdWord.word;
                lsuOpPkg::accByteU: loadData = {24'd0, selByte};
                lsuOpPkg::accHalfU: loadData = {16'd0, selHalf};
                default:            loadData = 32'd0;  // Decode has faulted it
            endcase
        end
    end

    assign rspNext = '{tag: tag, loadData: loadData, wasLoad: isLoad, fault: fault};

endmodule

`default_nettype wire

/* hw/lsuHandshake.sv */
`timescale 1ns/1ps
`default_nettype none

module lsuHandshake (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   reqIn,
    input  wire                   memReady,
    input  wire memPkg::lsuRsp_t  rspNext,
    output logic                  ackOut,
    output logic                  capture,
    output memPkg::lsuRsp_t       rsp
);

    typedef enum logic [2:0] {
        idle,
        decode,     // Decoder registers hold the request
        access,     // Memory write / read in flight
        respond,    // rsp latched, ack goes up next
        waitDrop    // ackOut high until reqIn falls
    } state_e;

    state_e state;

    // Take a request only when idle and the fill is complete
    assign capture = (state == idle) && reqIn && memReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= idle;
            ackOut <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (capture) begin
                        state <= decode;
                    end
                end
                decode: begin
                    state <= access;
                end
                access: begin
                    state <= respond;
                end
                respond: begin
                    ackOut <= 1'b1;
                    state  <= waitDrop;
                end
                waitDrop: begin
                    if (!reqIn) begin
                        ackOut <= 1'b0;
                        state  <= idle;
                    end
                end
                default: begin
                    ackOut <= 1'b0;
                    state  <= idle;
                end
            endcase
        end
    end

    // Response payload, held through the whole ack phase
    always_ff @(posedge clk) begin
        if (state == access) begin
            rsp <= rspNext;
        end
    end

    noCaptureDuringAck: assert property (@(posedge clk) disable iff (reset)
        capture |-> !ackOut);

    ackHeldUntilDrop: assert property (@(posedge clk) disable iff (reset)
        (ackOut && reqIn) |=> ackOut);

endmodule

`default_nettype wire

/* hw/lsuOpPkg.sv */
`default_nettype none

`include "lsu_params.svh"

// Instruction-side view of a load/store
package lsuOpPkg;

    // RV32 funct3 codes for loads and stores
    typedef enum logic [2:0] {
        accByte  = 3'b000,     // LB / SB
        accHalf  = 3'b001,     // LH / SH
        accWord  = 3'b010,     // LW / SW
        accByteU = 3'b100,     // LBU
        accHalfU = 3'b101      // LHU
    } accessCode_e;

    // One request as presented on the handshake link
    typedef struct packed {
        logic                  isLoad;
        logic                  isStore;
        logic [`LSU_TAG_W-1:0] tag;       // Echoed back in the response
        accessCode_e           funct3;
        logic [31:0]           addr;      // Byte address
        logic [31:0]           storeData; // Unshifted register value
    } lsuReq_t;

endpackage

`default_nettype wire

/* hw/lsuTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsuTop (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    reqIn,
    input  wire lsuOpPkg::lsuReq_t reqData,
    output logic                   ackOut,
    output memPkg::lsuRsp_t        rsp
);

    logic                       capture;
    logic                       memReady;
    memPkg::memWrite_t          memWr;
    logic [`LSU_WORD_IDX_W-1:0] rdIdx;
    memPkg::laneSel_t           lane;
    logic [`LSU_TAG_W-1:0]      tag;
    logic                       isLoad;
    logic                       fault;
    memPkg::memWord_u           rdWord;
    memPkg::lsuRsp_t            rspNext;

    lsuHandshake u_handshake (
        .clk      (clk),
        .reset    (reset),
        .reqIn    (reqIn),
        .memReady (memReady),
        .rspNext  (rspNext),
        .ackOut   (ackOut),
        .capture  (capture),
        .rsp      (rsp)
    );

    accessDecode u_decode (
        .clk     (clk),
        .reset   (reset),
        .capture (capture),
        .reqData (reqData),
        .memWr   (memWr),
        .rdIdx   (rdIdx),
        .lane    (lane),
        .tag     (tag),
        .isLoad  (isLoad),
        .fault   (fault)
    );

    dataMemory u_mem (
        .clk    (clk),
        .reset  (reset),
        .memWr  (memWr),
        .rdIdx  (rdIdx),
        .rdWord (rdWord),
        .ready  (memReady)
    );

    loadExtract u_extract (
        .rdWord  (rdWord),
        .lane    (lane),
        .tag     (tag),
        .isLoad  (isLoad),
        .fault   (fault),
        .rspNext (rspNext)
    );

endmodule

`default_nettype wire

/* hw/memPkg.sv */
`default_nettype none

`include "lsu_params.svh"

// Memory-side types shared by decode, storage and extraction
package memPkg;

    // A memory word seen whole, as byte lanes or as halfword lanes
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } memWord_u;

    typedef struct packed {
        logic                      writeEn;
        logic [`LSU_WORD_IDX_W-1:0] wordIdx;
        logic [3:0]                byteEn;
        memWord_u                  wrData;  // Already placed in its lanes
    } memWrite_t;

    typedef struct packed {
        logic [`LSU_TAG_W-1:0] tag;
        logic [31:0]           loadData;  // Zero for stores and faults
        logic                  wasLoad;
        logic                  fault;
    } lsuRsp_t;

    // What the extractor needs to pick a lane
    typedef struct packed {
        logic [1:0]            offset;
        lsuOpPkg::accessCode_e funct3;
    } laneSel_t;

endpackage

`default_nettype wire

/* include/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data memory geometry
`define LSU_MEM_WORDS 2048      // 32-bit words, 8 KiB total
`define LSU_WORD_IDX_W 11       // log2 of LSU_MEM_WORDS

// Instruction tag carried with every access
`define LSU_TAG_W 32

`endif

/* list.f */
+incdir+include
hw/lsuOpPkg.sv
hw/memPkg.sv
hw/accessDecode.sv
hw/dataMemory.sv
hw/loadExtract.sv
hw/lsuHandshake.sv
hw/lsuTop.sv
dv/lsuTb.sv
